// File: hdl/mrd_pkg.sv
`default_nettype none

package mrd_pkg;

	localparam int n_bank = 7; // Banks, and the radix of the stage.
	localparam int cnt_w = 12;

	// Sink-phase cycles before the watchdog fires.
	localparam logic [cnt_w-1:0] overtime_limit = 12'd2047;

	localparam int twdl_lead = 5; // Samples between twdl_sop and sink_3_4.

	// Codes 3 and 4 belong to the reorder and write-back phases of the full engine.
	typedef enum logic [2:0] {
		idle       = 3'd0,
		sink       = 3'd1,
		wait_to_rd = 3'd2,
		source     = 3'd5
	} mrd_phase_t;

endpackage

`default_nettype wire

// File: hdl/mrd_ctrl_fsm.sv
`default_nettype none

module mrd_ctrl_fsm
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       frame_done,
	input  logic       read_done,
	output mrd_phase_t phase,
	output logic       over_time,
	output logic       busy
);

	mrd_phase_t       phase_nxt;
	logic             drain_cnt;
	logic [cnt_w-1:0] cnt_ot;

	always_comb begin
		phase_nxt = phase;
		case (phase)
			idle: begin
				if (in_valid)
					phase_nxt = sink;
			end
			sink: begin
				if (frame_done)
					phase_nxt = wait_to_rd;
			end
			wait_to_rd: begin
				if (drain_cnt) // Second drain cycle.
					phase_nxt = source;
			end
			source: begin
				if (read_done)
					phase_nxt = idle;
			end
			default: phase_nxt = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase     <= idle;
			drain_cnt <= 1'b0;
		end else begin
			phase     <= phase_nxt;
			drain_cnt <= (phase == wait_to_rd) ? ~drain_cnt : 1'b0;
		end
	end

	// Watchdog on the length of the sink phase.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_ot    <= '0;
			over_time <= 1'b0;
		end else begin
			if (phase == sink) begin
				if (cnt_ot != overtime_limit)
					cnt_ot <= cnt_ot + 1'b1; // Saturates at the limit.
			end else begin
				cnt_ot <= '0;
			end
			if (phase != sink || frame_done)
				over_time <= 1'b0; // Drops together with the phase.
			else if (cnt_ot == overtime_limit)
				over_time <= 1'b1;
		end
	end

	assign busy = (phase != idle);

	a_done_in_sink: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> phase == sink);

endmodule

`default_nettype wire

// File: hdl/mrd_sink.sv
`default_nettype none

module mrd_sink
	import mrd_pkg::*;
#(
	parameter int wADDR  = 9,
	parameter int data_w = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  mrd_phase_t        phase,
	input  logic [cnt_w-1:0]  frame_len,
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	output logic [wADDR-1:0]  wraddr,
	output logic [n_bank-1:0] wren,
	output logic [data_w-1:0] wrdata,
	output logic [wADDR-1:0]  frame_groups,
	output logic              frame_done,
	output logic              sink_3_4,
	output logic              twdl_sop
);

	localparam int idx_w = $clog2(n_bank);

	logic [idx_w-1:0]  idx_pre;
	logic [idx_w-1:0]  idx_s1;
	logic [wADDR-1:0]  addr_pre;
	logic [wADDR-1:0]  addr_s1;
	logic              v_s1;
	logic [data_w-1:0] data_s1;
	logic [cnt_w-1:0]  cnt_sink;
	logic [cnt_w-1:0]  thr_3_4;
	logic [cnt_w-1:0]  thr_twdl;

	// Three quarters of the frame, minus one.
	assign thr_3_4  = (frame_len >> 2) + (frame_len >> 1) - 1'b1;
	assign thr_twdl = thr_3_4 - cnt_w'(twdl_lead);

	// Index and group address of the next sample.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx_pre  <= '0;
			addr_pre <= '0;
		end else if (in_valid) begin
			if (idx_pre == idx_w'(n_bank - 1)) begin
				idx_pre  <= '0;
				addr_pre <= addr_pre + 1'b1;
			end else begin
				idx_pre <= idx_pre + 1'b1;
			end
		end else begin
			idx_pre  <= '0;
			addr_pre <= '0;
		end
	end

	always_ff @(posedge clk) begin
		idx_s1  <= idx_pre;
		addr_s1 <= addr_pre;
		data_s1 <= in_data;
		wraddr  <= addr_s1;
		wrdata  <= data_s1;
	end

	// Write strobes, MSB first: bank 0 is bit n_bank-1.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v_s1 <= 1'b0;
			wren <= '0;
		end else begin
			v_s1 <= in_valid;
			wren <= '0;
			if (v_s1)
				wren[n_bank-1-idx_s1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_sink     <= '0;
			sink_3_4     <= 1'b0;
			twdl_sop     <= 1'b0;
			frame_done   <= 1'b0;
			frame_groups <= '0;
		end else begin
			cnt_sink   <= in_valid ? cnt_sink + 1'b1 : '0;
			sink_3_4   <= in_valid && (cnt_sink == thr_3_4);
			twdl_sop   <= in_valid && (cnt_sink == thr_twdl);
			frame_done <= v_s1 && !in_valid;
			// A partial last group still counts.
			if (v_s1 && !in_valid)
				frame_groups <= addr_pre + wADDR'(idx_pre != '0);
		end
	end

	// Back to back strobes step to the next bank and wrap after the last.
	a_wren_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(wren) && ($past(wren) == '0 || wren == '0
			|| wren == {$past(wren[0]), $past(wren[n_bank-1:1])}));

	a_valid_phase: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (phase == idle || phase == sink));

endmodule

`default_nettype wire

// File: hdl/mrd_bank_ram.sv
`default_nettype none

module mrd_bank_ram #(
	parameter int wADDR  = 9,
	parameter int data_w = 16
) (
	input  logic              clk,
	input  logic              wren,
	input  logic [wADDR-1:0]  wraddr,
	input  logic [data_w-1:0] wrdata,
	input  logic              rden,
	input  logic [wADDR-1:0]  rdaddr,
	output logic [data_w-1:0] rddata
);

	logic [data_w-1:0] mem [2**wADDR];

	always_ff @(posedge clk) begin
		if (wren)
			mem[wraddr] <= wrdata;
	end

	// One cycle read latency.
	always_ff @(posedge clk) begin
		if (rden)
			rddata <= mem[rdaddr];
	end

endmodule

`default_nettype wire

// File: hdl/mrd_source.sv
`default_nettype none

module mrd_source
	import mrd_pkg::*;
#(
	parameter int wADDR  = 9,
	parameter int data_w = 16
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  mrd_phase_t                    phase,
	input  logic [wADDR-1:0]              frame_groups,
	input  logic [n_bank-1:0][data_w-1:0] rddata,
	output logic [wADDR-1:0]              rdaddr,
	output logic                          rden,
	output logic                          read_done,
	output logic                          out_valid,
	output logic [n_bank-1:0][data_w-1:0] out_data
);

	logic [wADDR-1:0] rd_next;
	logic             rd_issued;
	logic             rd_last;
	logic             rden_d1;
	logic             last_d1;

	// One group address per cycle, once per source phase.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rden      <= 1'b0;
			rd_next   <= '0;
			rd_issued <= 1'b0;
			rd_last   <= 1'b0;
		end else if (phase == source && !rd_issued) begin
			rden      <= 1'b1;
			rd_next   <= rd_next + 1'b1;
			rd_last   <= (rd_next == frame_groups - 1'b1);
			rd_issued <= (rd_next == frame_groups - 1'b1);
		end else begin
			rden    <= 1'b0;
			rd_last <= 1'b0;
			if (phase != source) begin
				rd_next   <= '0;
				rd_issued <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		rdaddr <= rd_next;
	end

	// Match the bank read latency.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rden_d1   <= 1'b0;
			last_d1   <= 1'b0;
			out_valid <= 1'b0;
			read_done <= 1'b0;
		end else begin
			rden_d1   <= rden;
			last_d1   <= rd_last;
			out_valid <= rden_d1;
			read_done <= last_d1;
		end
	end

	// Bank vectors are MSB first, lanes are not.
	always_ff @(posedge clk) begin
		if (rden_d1) begin
			for (int j = 0; j < n_bank; j++)
				out_data[j] <= rddata[n_bank-1-j];
		end
	end

	a_rdaddr_range: assert property (@(posedge clk) disable iff (!rst_n)
		rden |-> rdaddr < frame_groups);

endmodule

`default_nettype wire

// File: hdl/mrd_top.sv
`default_nettype none

module mrd_top
	import mrd_pkg::*;
#(
	parameter int wADDR  = 9,
	parameter int data_w = 16
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cnt_w-1:0]              frame_len,
	input  logic                          in_valid,
	input  logic [data_w-1:0]             in_data,
	output logic                          out_valid,
	output logic [n_bank-1:0][data_w-1:0] out_data,
	output logic                          sink_3_4,
	output logic                          twdl_sop,
	output logic                          over_time,
	output logic                          busy
);

	mrd_phase_t                    phase;
	logic [wADDR-1:0]              wraddr;
	logic [n_bank-1:0]             wren;
	logic [data_w-1:0]             wrdata;
	logic [wADDR-1:0]              frame_groups;
	logic                          frame_done;
	logic [wADDR-1:0]              rdaddr;
	logic                          rden;
	logic [n_bank-1:0][data_w-1:0] rddata;
	logic                          read_done;

	mrd_ctrl_fsm u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.frame_done (frame_done),
		.read_done  (read_done),
		.phase      (phase),
		.over_time  (over_time),
		.busy       (busy)
	);

	mrd_sink #(.wADDR(wADDR), .data_w(data_w)) u_sink (
		.clk          (clk),
		.rst_n        (rst_n),
		.phase        (phase),
		.frame_len    (frame_len),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.wraddr       (wraddr),
		.wren         (wren),
		.wrdata       (wrdata),
		.frame_groups (frame_groups),
		.frame_done   (frame_done),
		.sink_3_4     (sink_3_4),
		.twdl_sop     (twdl_sop)
	);

	// Bank b sits at bit n_bank-1-b of the strobe and read vectors.
	for (genvar b = 0; b < n_bank; b++) begin : g_bank
		mrd_bank_ram #(.wADDR(wADDR), .data_w(data_w)) u_bank (
			.clk    (clk),
			.wren   (wren[n_bank-1-b]),
			.wraddr (wraddr),
			.wrdata (wrdata),
			.rden   (rden),
			.rdaddr (rdaddr),
			.rddata (rddata[n_bank-1-b])
		);
	end

	mrd_source #(.wADDR(wADDR), .data_w(data_w)) u_source (
		.clk          (clk),
		.rst_n        (rst_n),
		.phase        (phase),
		.frame_groups (frame_groups),
		.rddata       (rddata),
		.rdaddr       (rdaddr),
		.rden         (rden),
		.read_done    (read_done),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

endmodule

`default_nettype wire

// File: test/mrd_tb.sv
`default_nettype none

module mrd_tb
	import mrd_pkg::*;
();

	localparam int addr_w   = 9;
	localparam int data_w   = 16;
	localparam int n_frames = 9;

	logic                          clk;
	logic                          rst_n;
	logic [cnt_w-1:0]              frame_len;
	logic                          in_valid;
	logic [data_w-1:0]             in_data;
	logic                          out_valid;
	logic [n_bank-1:0][data_w-1:0] out_data;
	logic                          sink_3_4;
	logic                          twdl_sop;
	logic                          over_time;
	logic                          busy;

	// Reference model state.
	logic [data_w-1:0]             sent_q[$];
	logic [n_bank-1:0][data_w-1:0] exp_word;
	logic                          exp_avail;
	logic                          exp_34;
	logic                          exp_twdl;
	logic                          ot_seen;
	int                            pending;
	int                            vcnt; // Contiguous valid samples so far.
	int                            words;
	int                            n34;
	int                            ntw;
	int                            fail_cnt;
	int                            run_cycles;

	mrd_top #(.wADDR(addr_w), .data_w(data_w)) DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.frame_len (frame_len),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.sink_3_4  (sink_3_4),
		.twdl_sop  (twdl_sop),
		.over_time (over_time),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		fail_cnt++;
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// Oldest seven samples not yet seen at the output, lane j from sample j.
	function automatic logic [n_bank-1:0][data_w-1:0] head_group();
		logic [n_bank-1:0][data_w-1:0] w;
		int j;
		w = '0;
		for (j = 0; j < n_bank && j < sent_q.size(); j++)
			w[j] = sent_q[j];
		return w;
	endfunction

	task automatic send_frame(input int len);
		int k;
		@(posedge clk);
		frame_len <= cnt_w'(len);
		for (k = 0; k < len; k++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_data  <= data_w'($urandom);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_data  <= '0;
		@(posedge clk);
		while (busy)
			@(posedge clk);
		repeat (4) @(posedge clk); // Idle gap.
	endtask

	always @(posedge clk) begin : monitor
		int snum;
		int t_mark;
		snum   = vcnt + 1; // Sample number on this edge, from one.
		t_mark = int'(frame_len) / 4 + int'(frame_len) / 2 - 1;
		if (!rst_n) begin
			sent_q.delete();
			exp_word  <= '0;
			exp_avail <= 1'b0;
			exp_34    <= 1'b0;
			exp_twdl  <= 1'b0;
			ot_seen   <= 1'b0;
			pending   <= 0;
			vcnt      <= 0;
			words     <= 0;
			n34       <= 0;
			ntw       <= 0;
		end else begin
			if (in_valid)
				sent_q.push_back(in_data);
			if (out_valid && sent_q.size() >= n_bank)
				repeat (n_bank) void'(sent_q.pop_front());
			vcnt      <= in_valid ? snum : 0;
			exp_34    <= in_valid && (snum == t_mark + 1);
			exp_twdl  <= in_valid && (snum == t_mark - twdl_lead + 1);
			exp_word  <= head_group();
			exp_avail <= (sent_q.size() >= n_bank);
			pending   <= sent_q.size();
			if (in_valid && !busy) begin // First sample of a frame.
				words   <= 0;
				n34     <= 0;
				ntw     <= 0;
				ot_seen <= 1'b0;
			end else begin
				if (out_valid)
					words <= words + 1;
				if (sink_3_4)
					n34 <= n34 + 1;
				if (twdl_sop)
					ntw <= ntw + 1;
				if (over_time)
					ot_seen <= 1'b1;
			end
		end
	end

	a_group_data: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> exp_avail && out_data == exp_word)
		else stop_with_error($sformatf("mismatch at %0t: word %0d differs from the sent samples",
			$time, words));

	a_word_count: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> words == frame_len / n_bank && pending == 0)
		else stop_with_error($sformatf("mismatch at %0t: %0d words for a frame of %0d samples",
			$time, words, frame_len));

	a_mark_34: assert property (@(posedge clk) disable iff (!rst_n)
		sink_3_4 == exp_34)
		else stop_with_error($sformatf("mismatch at %0t: sink_3_4 is %0b", $time, sink_3_4));

	a_mark_twdl: assert property (@(posedge clk) disable iff (!rst_n)
		twdl_sop == exp_twdl)
		else stop_with_error($sformatf("mismatch at %0t: twdl_sop is %0b", $time, twdl_sop));

	a_pulse_count: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> n34 == 1 && ntw == 1)
		else stop_with_error($sformatf("mismatch at %0t: %0d sink_3_4 and %0d twdl_sop pulses",
			$time, n34, ntw));

	// Rises on the cycle after the one that follows the limit in the sink phase.
	a_ot_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(over_time) |-> vcnt == int'(overtime_limit) + 2)
		else stop_with_error($sformatf("mismatch at %0t: over_time rose after %0d samples",
			$time, vcnt));

	a_ot_frame: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> ot_seen == (frame_len > overtime_limit))
		else stop_with_error($sformatf("mismatch at %0t: over_time seen %0b for length %0d",
			$time, ot_seen, frame_len));

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !out_valid && !sink_3_4 && !twdl_sop && !over_time)
		else stop_with_error($sformatf("mismatch at %0t: output active while idle", $time));

	a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!busy && !in_valid |=> !busy)
		else stop_with_error("busy rose without any input sample");

	a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
		!busy && in_valid |=> busy)
		else stop_with_error("busy stayed low after the first sample of a frame");

	initial begin
		wait (run_cycles != 0);
		repeat (run_cycles) @(posedge clk);
		stop_with_error($sformatf("timeout: run still going after %0d cycles", run_cycles));
	end

	initial begin
		int lens[$];
		int total;
		int i;
		rst_n     <= 1'b0;
		in_valid  <= 1'b0;
		in_data   <= '0;
		frame_len <= '0;
		fail_cnt = 0;
		void'($urandom(4901));
		total = 0;
		for (i = 0; i < n_frames; i++) begin
			if (i == 3)
				lens.push_back(2100); // Long enough to trip the watchdog.
			else
				lens.push_back(n_bank * (4 + int'($urandom_range(96))));
			total += lens[i];
		end
		run_cycles = 3 * total + 1000;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (i = 0; i < n_frames; i++)
			send_frame(lens[i]);
		repeat (5) @(posedge clk);
		if (fail_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_with_error("run ended after failed checks");
		end
	end

endmodule

`default_nettype wire

// File: mrd_top.f
hdl/mrd_pkg.sv
hdl/mrd_ctrl_fsm.sv
hdl/mrd_sink.sv
hdl/mrd_bank_ram.sv
hdl/mrd_source.sv
hdl/mrd_top.sv
test/mrd_tb.sv

// File: Bender.yml
package:
  name: mrd

sources:
  - hdl/mrd_pkg.sv
  - hdl/mrd_ctrl_fsm.sv
  - hdl/mrd_sink.sv
  - hdl/mrd_bank_ram.sv
  - hdl/mrd_source.sv
  - hdl/mrd_top.sv
  - target: test
    files:
      - test/mrd_tb.sv
